/* hw/pipe_pkg.sv */
package pipe_pkg;

    // Slot state, one per pipeline position
    typedef enum logic [2:0] {
        EMPTY,
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } stage_t;

    // Opcode class, carried untouched from issue to report
    typedef enum logic [1:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_NOP
    } opcode_t;

    localparam int NUM_STAGES = 5;
    localparam int ID_W = 8;
    localparam int OCC_W = $clog2(NUM_STAGES + 1);

    // Fixed slot position of each stage
    localparam int FETCH_SLOT = 0;
    localparam int DECODE_SLOT = 1;
    localparam int EXEC_SLOT = 2;
    localparam int WB_SLOT = NUM_STAGES - 1;

endpackage

/* hw/pipe_trace_top.sv */
`timescale 1ns/1ps

module pipe_trace_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue,
    input  pipe_pkg::opcode_t             issue_op,
    input  logic                          stall,
    input  logic                          report_hold,
    output logic                          fetch_busy,
    output logic                          report_valid,
    output logic [pipe_pkg::ID_W-1:0]     report_id,
    output pipe_pkg::opcode_t             report_op,
    output logic [trace_pkg::STALL_W-1:0] report_stalls,
    output logic [trace_pkg::LAT_W-1:0]   report_latency,
    output logic [trace_pkg::TOTAL_W-1:0] retired_total,
    output logic [trace_pkg::TOTAL_W-1:0] stall_total
);
    import pipe_pkg::*;
    import trace_pkg::*;

    logic [CYCLE_W-1:0] cycle;

    // Tracker to buffer
    logic               push;
    logic [ID_W-1:0]    push_id;
    opcode_t            push_op;
    logic [CYCLE_W-1:0] push_issue_cycle;
    logic [CYCLE_W-1:0] push_wb_cycle;
    logic [STALL_W-1:0] push_stalls;
    logic [CNT_W-1:0]   fifo_count;

    // Buffer to reporter
    logic               fifo_empty;
    logic               pop;
    logic [ID_W-1:0]    head_id;
    opcode_t            head_op;
    logic [CYCLE_W-1:0] head_issue_cycle;
    logic [CYCLE_W-1:0] head_wb_cycle;
    logic [STALL_W-1:0] head_stalls;

    // Shared timestamp for issue and writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    stage_tracker u_stage_tracker (
        .clk              (clk),
        .rst              (rst),
        .issue            (issue),
        .issue_op         (issue_op),
        .stall            (stall),
        .cycle            (cycle),
        .fifo_count       (fifo_count),
        .fetch_busy       (fetch_busy),
        .push             (push),
        .push_id          (push_id),
        .push_op          (push_op),
        .push_issue_cycle (push_issue_cycle),
        .push_wb_cycle    (push_wb_cycle),
        .push_stalls      (push_stalls)
    );

    trace_fifo u_trace_fifo (
        .clk              (clk),
        .rst              (rst),
        .push             (push),
        .push_id          (push_id),
        .push_op          (push_op),
        .push_issue_cycle (push_issue_cycle),
        .push_wb_cycle    (push_wb_cycle),
        .push_stalls      (push_stalls),
        .pop              (pop),
        .empty            (fifo_empty),
        .count            (fifo_count),
        .head_id          (head_id),
        .head_op          (head_op),
        .head_issue_cycle (head_issue_cycle),
        .head_wb_cycle    (head_wb_cycle),
        .head_stalls      (head_stalls)
    );

    trace_reporter u_trace_reporter (
        .clk              (clk),
        .rst              (rst),
        .report_hold      (report_hold),
        .empty            (fifo_empty),
        .head_id          (head_id),
        .head_op          (head_op),
        .head_issue_cycle (head_issue_cycle),
        .head_wb_cycle    (head_wb_cycle),
        .head_stalls      (head_stalls),
        .pop              (pop),
        .report_valid     (report_valid),
        .report_id        (report_id),
        .report_op        (report_op),
        .report_stalls    (report_stalls),
        .report_latency   (report_latency),
        .retired_total    (retired_total),
        .stall_total      (stall_total)
    );

endmodule

/* hw/stage_tracker.sv */
`timescale 1ns/1ps

module stage_tracker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue,
    input  pipe_pkg::opcode_t           issue_op,
    input  logic                        stall,
    input  logic [trace_pkg::CYCLE_W-1:0] cycle,
    input  logic [trace_pkg::CNT_W-1:0] fifo_count,
    output logic                        fetch_busy,
    output logic                        push,
    output logic [pipe_pkg::ID_W-1:0]   push_id,
    output pipe_pkg::opcode_t           push_op,
    output logic [trace_pkg::CYCLE_W-1:0] push_issue_cycle,
    output logic [trace_pkg::CYCLE_W-1:0] push_wb_cycle,
    output logic [trace_pkg::STALL_W-1:0] push_stalls
);
    import pipe_pkg::*;
    import trace_pkg::*;

    // One slot per stage position
    stage_t               slot_stage  [NUM_STAGES];
    logic [ID_W-1:0]      slot_id     [NUM_STAGES];
    opcode_t              slot_op     [NUM_STAGES];
    logic [CYCLE_W-1:0]   slot_issue  [NUM_STAGES];
    logic [STALL_W-1:0]   slot_stalls [NUM_STAGES];

    logic [ID_W-1:0]      next_id;
    logic [OCC_W-1:0]     occupied;
    logic [CNT_W:0]       reserved;
    logic                 accept;

    // Stage an instruction takes after leaving the given one
    function automatic stage_t next_stage(input stage_t cur);
        stage_t nxt;
        case (cur)
            FETCH:   nxt = DECODE;
            DECODE:  nxt = EXECUTE;
            EXECUTE: nxt = MEMORY;
            MEMORY:  nxt = WRITEBACK;
            default: nxt = EMPTY;
        endcase
        return nxt;
    endfunction

    always_comb begin
        occupied = '0;
        for (int i = 0; i < NUM_STAGES; i++) begin
            if (slot_stage[i] != EMPTY) begin
                occupied = occupied + 1'b1;
            end
        end
    end

    // Records already buffered plus those still in flight
    assign reserved = {1'b0, fifo_count} + (CNT_W + 1)'(occupied);

    // Only a stall keeps an occupied fetch slot from advancing
    assign fetch_busy = stall || (reserved >= (CNT_W + 1)'(FIFO_DEPTH));
    assign accept = issue && !fetch_busy;

    // Stage control
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_STAGES; i++) begin
                slot_stage[i] <= EMPTY;
            end
            next_id <= '0;
        end else begin
            for (int i = EXEC_SLOT + 1; i < NUM_STAGES; i++) begin
                slot_stage[i] <= next_stage(slot_stage[i-1]);
            end

            if (stall) begin
                // Fetch and decode hold while a bubble goes down the pipe
                slot_stage[EXEC_SLOT] <= EMPTY;
            end else begin
                slot_stage[EXEC_SLOT] <= next_stage(slot_stage[DECODE_SLOT]);
                slot_stage[DECODE_SLOT] <= next_stage(slot_stage[FETCH_SLOT]);
                slot_stage[FETCH_SLOT] <= accept ? FETCH : EMPTY;
            end

            if (accept) begin
                next_id <= next_id + 1'b1;
            end
        end
    end

    // Slot payload follows the stage shift
    always_ff @(posedge clk) begin
        for (int i = EXEC_SLOT; i < NUM_STAGES; i++) begin
            slot_id[i]     <= slot_id[i-1];
            slot_op[i]     <= slot_op[i-1];
            slot_issue[i]  <= slot_issue[i-1];
            slot_stalls[i] <= slot_stalls[i-1];
        end

        if (stall) begin
            // Count held decode cycles up to all ones
            if (slot_stage[DECODE_SLOT] != EMPTY && slot_stalls[DECODE_SLOT] != '1) begin
                slot_stalls[DECODE_SLOT] <= slot_stalls[DECODE_SLOT] + 1'b1;
            end
        end else begin
            slot_id[DECODE_SLOT]     <= slot_id[FETCH_SLOT];
            slot_op[DECODE_SLOT]     <= slot_op[FETCH_SLOT];
            slot_issue[DECODE_SLOT]  <= slot_issue[FETCH_SLOT];
            slot_stalls[DECODE_SLOT] <= slot_stalls[FETCH_SLOT];
        end

        if (accept) begin
            slot_id[FETCH_SLOT]     <= next_id;
            slot_op[FETCH_SLOT]     <= issue_op;
            // Timestamp of the first fetch cycle
            slot_issue[FETCH_SLOT]  <= cycle + 1'b1;
            slot_stalls[FETCH_SLOT] <= '0;
        end
    end

    // Completion record leaves in the writeback cycle
    assign push             = (slot_stage[WB_SLOT] == WRITEBACK);
    assign push_id          = slot_id[WB_SLOT];
    assign push_op          = slot_op[WB_SLOT];
    assign push_issue_cycle = slot_issue[WB_SLOT];
    assign push_wb_cycle    = cycle;
    assign push_stalls      = slot_stalls[WB_SLOT];

endmodule

/* hw/trace_fifo.sv */
`timescale 1ns/1ps

module trace_fifo (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  logic [pipe_pkg::ID_W-1:0]     push_id,
    input  pipe_pkg::opcode_t             push_op,
    input  logic [trace_pkg::CYCLE_W-1:0] push_issue_cycle,
    input  logic [trace_pkg::CYCLE_W-1:0] push_wb_cycle,
    input  logic [trace_pkg::STALL_W-1:0] push_stalls,
    input  logic                          pop,
    output logic                          empty,
    output logic [trace_pkg::CNT_W-1:0]   count,
    output logic [pipe_pkg::ID_W-1:0]     head_id,
    output pipe_pkg::opcode_t             head_op,
    output logic [trace_pkg::CYCLE_W-1:0] head_issue_cycle,
    output logic [trace_pkg::CYCLE_W-1:0] head_wb_cycle,
    output logic [trace_pkg::STALL_W-1:0] head_stalls
);
    import pipe_pkg::*;
    import trace_pkg::*;

    logic [ID_W-1:0]    mem_id     [FIFO_DEPTH];
    opcode_t            mem_op     [FIFO_DEPTH];
    logic [CYCLE_W-1:0] mem_issue  [FIFO_DEPTH];
    logic [CYCLE_W-1:0] mem_wb     [FIFO_DEPTH];
    logic [STALL_W-1:0] mem_stalls [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign do_push = push && (count != CNT_W'(FIFO_DEPTH));
    assign do_pop  = pop && !empty;

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_id[wr_ptr]     <= push_id;
            mem_op[wr_ptr]     <= push_op;
            mem_issue[wr_ptr]  <= push_issue_cycle;
            mem_wb[wr_ptr]     <= push_wb_cycle;
            mem_stalls[wr_ptr] <= push_stalls;
        end
    end

    // Head record is read straight from the array
    assign head_id          = mem_id[rd_ptr];
    assign head_op          = mem_op[rd_ptr];
    assign head_issue_cycle = mem_issue[rd_ptr];
    assign head_wb_cycle    = mem_wb[rd_ptr];
    assign head_stalls      = mem_stalls[rd_ptr];

endmodule

/* hw/trace_pkg.sv */
package trace_pkg;

    // Free-running timestamp, wraps
    localparam int CYCLE_W = 16;

    // Per-instruction decode stall count, saturates
    localparam int STALL_W = 8;

    // Record buffer
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Reporter results
    localparam int LAT_W = 16;
    localparam int TOTAL_W = 24;

endpackage

/* hw/trace_reporter.sv */
`timescale 1ns/1ps

module trace_reporter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          report_hold,
    input  logic                          empty,
    input  logic [pipe_pkg::ID_W-1:0]     head_id,
    input  pipe_pkg::opcode_t             head_op,
    input  logic [trace_pkg::CYCLE_W-1:0] head_issue_cycle,
    input  logic [trace_pkg::CYCLE_W-1:0] head_wb_cycle,
    input  logic [trace_pkg::STALL_W-1:0] head_stalls,
    output logic                          pop,
    output logic                          report_valid,
    output logic [pipe_pkg::ID_W-1:0]     report_id,
    output pipe_pkg::opcode_t             report_op,
    output logic [trace_pkg::STALL_W-1:0] report_stalls,
    output logic [trace_pkg::LAT_W-1:0]   report_latency,
    output logic [trace_pkg::TOTAL_W-1:0] retired_total,
    output logic [trace_pkg::TOTAL_W-1:0] stall_total
);
    import trace_pkg::*;

    logic [CYCLE_W-1:0] lat_diff;

    // Drain whenever a record waits and the sink is not holding
    assign pop = !empty && !report_hold;

    // Modulo difference handles a wrapped timestamp
    assign lat_diff = head_wb_cycle - head_issue_cycle;

    always_ff @(posedge clk) begin
        if (rst) begin
            report_valid  <= 1'b0;
            retired_total <= '0;
            stall_total   <= '0;
        end else begin
            report_valid <= pop;
            if (pop) begin
                retired_total <= retired_total + 1'b1;
                stall_total   <= stall_total + TOTAL_W'(head_stalls);
            end
        end
    end

    // Record fields, only meaningful with report_valid
    always_ff @(posedge clk) begin
        if (pop) begin
            report_id      <= head_id;
            report_op      <= head_op;
            report_stalls  <= head_stalls;
            report_latency <= LAT_W'(lat_diff);
        end
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pipe_trace -f tb.f -o tb_pipe_trace
./obj_dir/tb_pipe_trace 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation PASSED"

/* tb.f */
hw/pipe_pkg.sv
hw/trace_pkg.sv
hw/stage_tracker.sv
hw/trace_fifo.sv
hw/trace_reporter.sv
hw/pipe_trace_top.sv
test/tb_pipe_trace.sv

/* test/tb_pipe_trace.sv */
`timescale 1ns/1ps

module tb_pipe_trace;
    import pipe_pkg::*;
    import trace_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'd65964;
    localparam int HOLD_LIMIT  = 64;
    localparam int DRAIN_LIMIT = 400;
    localparam int STALL_MAX   = 2**STALL_W - 1;
    // Model positions from fetch through writeback, then the buffer
    localparam int POS_FETCH  = 0;
    localparam int POS_DECODE = 1;
    localparam int POS_FIFO   = 5;

    typedef struct {
        logic [ID_W-1:0] id;
        opcode_t         op;
        int              pos;
        int              extra;
        int              stalls;
    } entry_t;

    logic               clk;
    logic               rst;
    logic               issue;
    opcode_t            issue_op;
    logic               stall;
    logic               report_hold;
    logic               fetch_busy;
    logic               report_valid;
    logic [ID_W-1:0]    report_id;
    opcode_t            report_op;
    logic [STALL_W-1:0] report_stalls;
    logic [LAT_W-1:0]   report_latency;
    logic [TOTAL_W-1:0] retired_total;
    logic [TOTAL_W-1:0] stall_total;

    // Reference model holds every accepted instruction until it is popped
    entry_t             model_q[$];
    logic [ID_W-1:0]    model_id;
    int                 in_flight;
    int                 issued_total;
    logic               exp_busy;
    logic               exp_valid;
    logic [ID_W-1:0]    exp_id;
    opcode_t            exp_op;
    logic [STALL_W-1:0] exp_stalls;
    logic [LAT_W-1:0]   exp_lat;
    logic [TOTAL_W-1:0] exp_retired;
    logic [TOTAL_W-1:0] exp_stall_total;

    logic [31:0]        lfsr;
    int                 hold_left;

    pipe_trace_top u_pipe_trace_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        fail_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, want));
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    // In flight plus buffered records may not exceed the FIFO depth
    assign exp_busy = stall || (in_flight >= FIFO_DEPTH);

    always @(posedge clk) begin
        entry_t e;
        entry_t head;
        logic   popped;
        popped = 1'b0;
        if (rst) begin
            model_q.delete();
            model_id = '0;
            issued_total = 0;
            in_flight <= 0;
            exp_valid <= 1'b0;
            exp_retired <= '0;
            exp_stall_total <= '0;
        end else begin
            // Oldest buffered record leaves unless the sink holds
            if (model_q.size() > 0 && model_q[0].pos == POS_FIFO && !report_hold) begin
                head = model_q.pop_front();
                popped = 1'b1;
            end
            for (int i = 0; i < model_q.size(); i++) begin
                e = model_q[i];
                if ((e.pos <= POS_DECODE) && stall) begin
                    e.extra++;
                    if (e.pos == POS_DECODE && e.stalls < STALL_MAX) begin
                        e.stalls++;
                    end
                end else if (e.pos < POS_FIFO) begin
                    e.pos++;
                end
                model_q[i] = e;
            end
            if (issue && !exp_busy) begin
                e.id = model_id;
                e.op = issue_op;
                e.pos = POS_FETCH;
                e.extra = 0;
                e.stalls = 0;
                model_q.push_back(e);
                model_id = model_id + 1'b1;
                issued_total++;
            end
            exp_valid <= popped;
            if (popped) begin
                exp_id <= head.id;
                exp_op <= head.op;
                exp_stalls <= STALL_W'(head.stalls);
                exp_lat <= LAT_W'(4 + head.extra);
                exp_retired <= exp_retired + 1'b1;
                exp_stall_total <= exp_stall_total + TOTAL_W'(head.stalls);
            end
            in_flight <= model_q.size();
        end
    end

    assert property (@(posedge clk) disable iff (rst) fetch_busy == exp_busy)
        else report_mismatch("fetch_busy", 32'($sampled(fetch_busy)), 32'($sampled(exp_busy)));
    assert property (@(posedge clk) disable iff (rst) report_valid == exp_valid)
        else report_mismatch("report_valid", 32'($sampled(report_valid)),
                             32'($sampled(exp_valid)));
    assert property (@(posedge clk) disable iff (rst) !exp_valid || report_id == exp_id)
        else report_mismatch("report_id", 32'($sampled(report_id)), 32'($sampled(exp_id)));
    assert property (@(posedge clk) disable iff (rst) !exp_valid || report_op == exp_op)
        else report_mismatch("report_op", 32'($sampled(report_op)), 32'($sampled(exp_op)));
    assert property (@(posedge clk) disable iff (rst) !exp_valid || report_latency == exp_lat)
        else report_mismatch("report_latency", 32'($sampled(report_latency)),
                             32'($sampled(exp_lat)));
    assert property (@(posedge clk) disable iff (rst) !exp_valid || report_stalls == exp_stalls)
        else report_mismatch("report_stalls", 32'($sampled(report_stalls)),
                             32'($sampled(exp_stalls)));
    assert property (@(posedge clk) disable iff (rst) retired_total == exp_retired)
        else report_mismatch("retired_total", 32'($sampled(retired_total)),
                             32'($sampled(exp_retired)));
    assert property (@(posedge clk) disable iff (rst) stall_total == exp_stall_total)
        else report_mismatch("stall_total", 32'($sampled(stall_total)),
                             32'($sampled(exp_stall_total)));

    task automatic random_cycle(input logic use_stall, input logic use_hold);
        logic [7:0] bits;
        @(posedge clk);
        bits = take_bits(1);
        issue <= bits[0];
        bits = take_bits(2);
        issue_op <= opcode_t'(bits[1:0]);
        bits = take_bits(2);
        stall <= use_stall && (bits[1:0] == 2'b11);
        if (use_hold && hold_left == 0) begin
            bits = take_bits(3);
            if (bits[2:0] == 3'd0) begin
                bits = take_bits(4);
                hold_left = 4 + int'(bits[3:0]);
            end
        end
        report_hold <= (hold_left > 0);
        if (hold_left > 0) begin
            hold_left--;
        end
    endtask

    // Sink held while issue keeps knocking until the reservation fills up
    task automatic fill_under_hold();
        logic [7:0] bits;
        int         waited;
        waited = 0;
        @(posedge clk);
        issue <= 1'b1;
        stall <= 1'b0;
        report_hold <= 1'b1;
        while (!(fetch_busy && !stall) && waited < HOLD_LIMIT) begin
            @(posedge clk);
            bits = take_bits(2);
            issue_op <= opcode_t'(bits[1:0]);
            waited++;
        end
        if (!(fetch_busy && !stall)) begin
            fail_run("fetch_busy stayed low during a long report_hold");
        end else begin
            repeat (20) @(posedge clk);
            report_hold <= 1'b0;
        end
    endtask

    initial begin
        int waited;
        rst = 1'b1;
        issue = 1'b0;
        issue_op = OP_ALU;
        stall = 1'b0;
        report_hold = 1'b0;
        lfsr = LFSR_SEED;
        hold_left = 0;
        waited = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Clean issue stream first, then stalls and sink holds mixed in
        repeat (40) random_cycle(1'b0, 1'b0);
        repeat (900) random_cycle(1'b1, 1'b1);
        fill_under_hold();
        @(posedge clk);
        issue <= 1'b0;
        stall <= 1'b0;
        report_hold <= 1'b0;
        while ((in_flight != 0 || exp_valid) && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (in_flight != 0 || exp_valid) begin
            fail_run("Pipeline did not drain within the time limit");
        end else if (issued_total <= 256) begin
            fail_run("Too few instructions were accepted to wrap the sequence id");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule
